//--- build.f
+incdir+logic
logic/ahb_outstg_pkg.sv
logic/output_arb.sv
logic/addr_phase_mux.sv
logic/data_phase_ctrl.sv
logic/ahb_out_stage.sv
verification/tb_ahb_out_stage.sv

//--- Bender.yml
package:
  name: ahb_out_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ahb_outstg_pkg.sv
      - logic/output_arb.sv
      - logic/addr_phase_mux.sv
      - logic/data_phase_ctrl.sv
      - logic/ahb_out_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_ahb_out_stage.sv

//--- verification/tb_ahb_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_settings.svh"

module tb_ahb_out_stage;

  // ----------------------------------------------------------
  // Clock, run length and stimulus seed
  // ----------------------------------------------------------
  localparam int          CLK_PERIOD   = 4;              // ns
  localparam int          LEN_RESET    = 4;              // Cycles per test including margin
  localparam int          LEN_SINGLE   = 6;
  localparam int          LEN_PRIORITY = 10;
  localparam int          LEN_WDATA    = 10;
  localparam int          LEN_BURST    = 8;
  localparam int          LEN_LOCK     = 8;
  localparam int          RUN_CYCLES   = LEN_RESET + LEN_SINGLE + LEN_PRIORITY +
                                         LEN_WDATA + LEN_BURST + LEN_LOCK;
  localparam logic [31:0] LFSR_SEED    = 32'hc4ae_6746;

  logic                           HCLK = 1'b0;
  logic                           HRESETn;
  ahb_outstg_pkg::addr_ctrl_arr_t port_ac;               // Input stage address phases
  ahb_outstg_pkg::wdata_arr_t     port_wdata;            // Input stage write data
  logic                           hreadyoutm;            // Slave ready
  ahb_outstg_pkg::port_mask_t     active;
  ahb_outstg_pkg::addr_ctrl_t     slave_ac;
  logic [`OUTSTG_DATA_W-1:0]      hwdatam;
  logic                           hreadymuxm;

  logic [31:0] lfsr;                                     // Stimulus generator state
  string       cur_test;
  int          err_ac   = 0;
  int          err_mask = 0;
  int          err_word = 0;
  int          err_bit  = 0;

  ahb_out_stage i_ahb_out_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ac    (port_ac),
    .i_port_wdata (port_wdata),
    .i_hreadyoutm (hreadyoutm),
    .o_active     (active),
    .o_slave_ac   (slave_ac),
    .o_hwdatam    (hwdatam),
    .o_hreadymuxm (hreadymuxm)
  );

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};                         // One step per bit
    end
  endtask

  // Input stage holds a transfer whenever it addresses this slave
  function automatic ahb_outstg_pkg::addr_ctrl_t make_ac(input logic sel,
      input logic [1:0] trans, input logic write, input logic lock,
      input logic [3:0] master, input logic [31:0] addr);
    ahb_outstg_pkg::addr_ctrl_t ac;
    ac           = '0;
    ac.sel       = sel;
    ac.addr      = addr;
    ac.trans     = trans;
    ac.write     = write;
    ac.size      = 3'b010;                               // Word
    ac.burst     = 3'b001;                               // INCR
    ac.prot      = 4'b0011;
    ac.master    = master;
    ac.mastlock  = lock;
    ac.held_tran = sel;
    return ac;
  endfunction

  task automatic tick();
    @(posedge HCLK);
    #1;                                                  // Drive point
  endtask

  task automatic settle();
    @(negedge HCLK);                                     // Sample point
  endtask

  task automatic idle_ports();
    tick();                                              // Back to the drive point
    port_ac    = '0;
    hreadyoutm = 1'b1;
    tick();
    tick();                                              // Grant and data phase drain
  endtask

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_ac(input string what, input ahb_outstg_pkg::addr_ctrl_t exp,
                          input ahb_outstg_pkg::addr_ctrl_t act);
    ahb_outstg_pkg::addr_ctrl_t e;
    ahb_outstg_pkg::addr_ctrl_t a;
    e           = exp;
    a           = act;
    e.held_tran = 1'b0;                                  // Not part of slave bus
    a.held_tran = 1'b0;
    if (a !== e)
    begin
      err_ac++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, e, a);
    end
  endtask

  task automatic check_mask(input string what, input ahb_outstg_pkg::port_mask_t exp,
                            input ahb_outstg_pkg::port_mask_t act);
    if (act !== exp)
    begin
      err_mask++;
      $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [`OUTSTG_DATA_W-1:0] exp,
                            input logic [`OUTSTG_DATA_W-1:0] act);
    if (act !== exp)
    begin
      err_word++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_bit++;
      $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic reset_state();
    cur_test = "reset_state";
    settle();
    check_mask("o_active", '0, active);
    check_ac("o_slave_ac", '0, slave_ac);
    check_bit("o_hreadymuxm", 1'b1, hreadymuxm);
    tick();
  endtask

  task automatic single_request();
    logic [31:0]                addr;
    ahb_outstg_pkg::addr_ctrl_t ac;
    cur_test = "single_request";
    rand_word(addr);
    ac         = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b0, 4'd2, addr);
    port_ac[2] = ac;
    settle();
    check_mask("o_active before grant", '0, active);
    tick();
    settle();
    check_mask("o_active", 3'b100, active);              // Granted one edge later
    check_ac("o_slave_ac", ac, slave_ac);
    idle_ports();
  endtask

  task automatic fixed_priority();
    logic [31:0]                addr;
    ahb_outstg_pkg::addr_ctrl_t ac [`OUTSTG_N_PORTS];
    cur_test = "fixed_priority";
    for (int p = 0; p < `OUTSTG_N_PORTS; p++)
    begin
      rand_word(addr);
      ac[p]      = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b0, 4'(p), addr);
      port_ac[p] = ac[p];
    end
    tick();
    settle();
    check_mask("o_active port 0", 3'b001, active);
    check_ac("o_slave_ac port 0", ac[0], slave_ac);
    tick();
    port_ac[0] = '0;                                     // Port 0 goes IDLE
    settle();
    check_mask("o_active port 0 held", 3'b001, active);
    tick();
    settle();
    check_mask("o_active port 1", 3'b010, active);
    check_ac("o_slave_ac port 1", ac[1], slave_ac);
    tick();
    port_ac[1] = '0;
    tick();
    settle();
    check_mask("o_active port 2", 3'b100, active);
    check_ac("o_slave_ac port 2", ac[2], slave_ac);
    tick();
    port_ac[2] = '0;
    tick();
    settle();
    check_mask("o_active none", '0, active);
    check_ac("o_slave_ac none", '0, slave_ac);
    idle_ports();
  endtask

  task automatic write_data_stall();
    logic [31:0]                addr;
    logic [31:0]                word;
    ahb_outstg_pkg::addr_ctrl_t ac0;
    ahb_outstg_pkg::addr_ctrl_t ac1;
    cur_test = "write_data_stall";
    for (int p = 0; p < `OUTSTG_N_PORTS; p++)
    begin
      rand_word(word);
      port_wdata[p] = word;
    end
    rand_word(addr);
    ac1        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b1, 1'b0, 4'd1, addr);
    rand_word(addr);
    ac0        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b1, 1'b0, 4'd0, addr);
    port_ac[1] = ac1;
    tick();
    settle();
    check_mask("o_active port 1", 3'b010, active);
    check_ac("o_slave_ac port 1", ac1, slave_ac);
    tick();                                              // Port 1 address accepted
    port_ac[1] = '0;
    port_ac[0] = ac0;
    hreadyoutm = 1'b0;                                   // Slave stalls data phase
    settle();
    check_bit("o_hreadymuxm stall", 1'b0, hreadymuxm);
    check_word("o_hwdatam port 1", port_wdata[1], hwdatam);
    check_mask("o_active stall", 3'b010, active);
    tick();
    settle();
    check_bit("o_hreadymuxm still stalled", 1'b0, hreadymuxm);
    check_word("o_hwdatam frozen", port_wdata[1], hwdatam);
    check_mask("o_active frozen", 3'b010, active);
    tick();
    hreadyoutm = 1'b1;
    settle();
    check_bit("o_hreadymuxm released", 1'b1, hreadymuxm);
    check_mask("o_active before release edge", 3'b010, active);
    tick();
    settle();
    check_mask("o_active port 0", 3'b001, active);
    check_ac("o_slave_ac port 0", ac0, slave_ac);
    check_word("o_hwdatam after idle", port_wdata[1], hwdatam);
    tick();                                              // Port 0 address accepted
    port_ac[0] = '0;
    settle();
    check_word("o_hwdatam port 0", port_wdata[0], hwdatam);
    idle_ports();
  endtask

  task automatic burst_hold();
    logic [31:0]                addr;
    logic [31:0]                base;
    ahb_outstg_pkg::addr_ctrl_t ac0;
    ahb_outstg_pkg::addr_ctrl_t ac1;
    cur_test = "burst_hold";
    rand_word(base);
    rand_word(addr);
    ac0        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b0, 4'd0, addr);
    ac1        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b0, 4'd1, base);
    port_ac[1] = ac1;
    tick();
    settle();
    check_mask("o_active first beat", 3'b010, active);
    tick();
    ac1        = make_ac(1'b1, `OUTSTG_TRANS_SEQ, 1'b0, 1'b0, 4'd1, base + 32'd4);
    port_ac[1] = ac1;
    port_ac[0] = ac0;                                    // Higher priority arrives
    settle();
    check_ac("o_slave_ac second beat", ac1, slave_ac);
    tick();
    ac1        = make_ac(1'b1, `OUTSTG_TRANS_SEQ, 1'b0, 1'b0, 4'd1, base + 32'd8);
    port_ac[1] = ac1;
    settle();
    check_mask("o_active held on SEQ", 3'b010, active);
    check_ac("o_slave_ac third beat", ac1, slave_ac);
    tick();
    port_ac[1] = '0;                                     // Burst ends
    settle();
    check_mask("o_active held on last SEQ", 3'b010, active);
    tick();
    settle();
    check_mask("o_active port 0", 3'b001, active);
    check_ac("o_slave_ac port 0", ac0, slave_ac);
    idle_ports();
  endtask

  task automatic lock_hold();
    logic [31:0]                addr;
    ahb_outstg_pkg::addr_ctrl_t ac0;
    ahb_outstg_pkg::addr_ctrl_t ac2;
    cur_test = "lock_hold";
    rand_word(addr);
    ac0        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b0, 4'd0, addr);
    rand_word(addr);
    ac2        = make_ac(1'b1, `OUTSTG_TRANS_NONSEQ, 1'b1, 1'b1, 4'd2, addr);
    port_ac[2] = ac2;
    tick();
    settle();
    check_mask("o_active locked start", 3'b100, active);
    tick();
    rand_word(addr);
    ac2        = make_ac(1'b0, `OUTSTG_TRANS_NONSEQ, 1'b0, 1'b1, 4'd2, addr);
    port_ac[2] = ac2;                                    // Other slave while still locked
    port_ac[0] = ac0;
    settle();
    check_ac("o_slave_ac away", ac2, slave_ac);
    tick();
    settle();
    check_mask("o_active lock held", 3'b100, active);
    tick();
    port_ac[2] = '0;                                     // Lock released
    settle();
    check_mask("o_active lock last", 3'b100, active);
    tick();
    settle();
    check_mask("o_active port 0", 3'b001, active);
    check_ac("o_slave_ac port 0", ac0, slave_ac);
    idle_ports();
  endtask

  // ----------------------------------------------------------
  // Sequencer and watchdog
  // ----------------------------------------------------------
  initial
  begin
    int total;
    HRESETn    = 1'b0;
    port_ac    = '0;
    port_wdata = '0;
    hreadyoutm = 1'b1;
    lfsr       = LFSR_SEED;
    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    reset_state();
    single_request();
    fixed_priority();
    write_data_stall();
    burst_hold();
    lock_hold();
    total = err_ac + err_mask + err_word + err_bit;
    $display("Summary: %0d errors (addr/ctrl %0d, active %0d, wdata %0d, ready %0d)",
             total, err_ac, err_mask, err_word, err_bit);
    if (total == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  initial
  begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: tests did not complete in %0d cycles", 2 * RUN_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/ahb_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_settings.svh"

module ahb_out_stage (
  input  wire                                 HCLK,          // AHB clock
  input  wire                                 HRESETn,       // Sync reset, active low
  input  wire ahb_outstg_pkg::addr_ctrl_arr_t i_port_ac,     // From input stages
  input  wire ahb_outstg_pkg::wdata_arr_t     i_port_wdata,  // From input stages
  input  wire                                 i_hreadyoutm,  // Slave HREADYOUT
  output wire ahb_outstg_pkg::port_mask_t     o_active,      // Per-port ownership
  output wire ahb_outstg_pkg::addr_ctrl_t     o_slave_ac,    // Slave address phase
  output wire [`OUTSTG_DATA_W-1:0]            o_hwdatam,     // Slave HWDATA
  output wire                                 o_hreadymuxm   // Slave/ports HREADY
);

  // ----------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------
  ahb_outstg_pkg::grant_t grant;                         // Registered owner
  wire                    lock_arb;                      // Lock hold for arbiter

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------
  output_arb u_output_arb (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_port_ac   (i_port_ac),
    .i_lock_arb  (lock_arb),
    .i_hreadymux (o_hreadymuxm),
    .i_cur_trans (o_slave_ac.trans),                     // Burst hold check
    .o_grant     (grant)
  );

  // ----------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------
  addr_phase_mux u_addr_phase_mux (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_grant     (grant),
    .i_port_ac   (i_port_ac),
    .i_hreadymux (o_hreadymuxm),
    .o_slave_ac  (o_slave_ac),
    .o_active    (o_active),
    .o_lock_arb  (lock_arb)
  );

  // ----------------------------------------------------------
  // Data phase
  // ----------------------------------------------------------
  data_phase_ctrl u_data_phase_ctrl (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant      (grant),
    .i_slave_sel  (o_slave_ac.sel),                      // Captured per transfer
    .i_port_wdata (i_port_wdata),
    .i_hreadyoutm (i_hreadyoutm),
    .o_hwdatam    (o_hwdatam),
    .o_hreadymux  (o_hreadymuxm)                         // Also feeds both blocks
  );

endmodule

`default_nettype wire

//--- logic/data_phase_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_settings.svh"

module data_phase_ctrl (
  input  wire                               HCLK,        // AHB clock
  input  wire                               HRESETn,     // Sync reset, active low
  input  wire ahb_outstg_pkg::grant_t       i_grant,     // Current address owner
  input  wire                               i_slave_sel, // HSEL of current address
  input  wire ahb_outstg_pkg::wdata_arr_t   i_port_wdata, // HWDATA per port
  input  wire                               i_hreadyoutm, // Slave ready
  output logic [`OUTSTG_DATA_W-1:0]         o_hwdatam,   // Write data to slave
  output logic                              o_hreadymux  // Ready to slave and ports
);

  ahb_outstg_pkg::port_idx_t data_port;                  // Owner of data phase
  logic                      slave_sel;                  // Data phase targets slave

  // ----------------------------------------------------------
  // Data-phase registers
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= '0;
      slave_sel <= 1'b0;                                 // No data phase pending
    end
    else if (o_hreadymux)
    begin
      data_port <= i_grant.idx;                          // Address phase becomes data
      slave_sel <= i_slave_sel;
    end
  end

  // Write data lags address by one accepted transfer
  assign o_hwdatam = i_port_wdata[data_port];

  // ----------------------------------------------------------
  // HREADYMUX
  // ----------------------------------------------------------
  // Slave only stalls when the data phase is really its own
  assign o_hreadymux = slave_sel ? i_hreadyoutm : 1'b1;

  // Arbiter only ever hands out existing ports
  a_data_port_range : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    data_port < `OUTSTG_N_PORTS
  );

endmodule

`default_nettype wire

//--- logic/addr_phase_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_settings.svh"

module addr_phase_mux (
  input  wire                            HCLK,          // AHB clock
  input  wire                            HRESETn,       // Sync reset, active low
  input  wire ahb_outstg_pkg::grant_t    i_grant,       // Current owner
  input  wire ahb_outstg_pkg::addr_ctrl_arr_t i_port_ac,  // Address phase per port
  input  wire                            i_hreadymux,   // Transfer accepted this cycle
  output ahb_outstg_pkg::addr_ctrl_t     o_slave_ac,    // Address phase to slave
  output ahb_outstg_pkg::port_mask_t     o_active,      // One-hot owner flags
  output logic                           o_lock_arb     // Lock level for arbiter
);

  logic hsel_lock;                                       // Locked sequence owns us
  logic next_hsel_lock;                                  // Pre-registered hsel_lock

  // ----------------------------------------------------------
  // Address/control multiplexer
  // ----------------------------------------------------------
  always_comb
  begin
    o_slave_ac = '0;                                     // IDLE and unselected
    o_active   = '0;
    for (int p = 0; p < `OUTSTG_N_PORTS; p++)
    begin
      if (i_grant.valid && (i_grant.idx == p))
      begin
        o_slave_ac  = i_port_ac[p];                      // Owner drives the slave
        o_active[p] = 1'b1;                              // Tell the input stage
      end
    end
    o_slave_ac.held_tran = 1'b0;                         // Input-stage internal only
  end

  // ----------------------------------------------------------
  // Lock tracking
  // ----------------------------------------------------------
  // A locked master may briefly address another slave mid-sequence.
  // HSEL then drops while HMASTLOCK stays, and the sequence must
  // still own this output until the lock is released.
  always_comb
  begin
    if (o_slave_ac.sel && o_slave_ac.trans[1] && o_slave_ac.mastlock)
    begin
      next_hsel_lock = 1'b1;                             // Locked NONSEQ/SEQ to us
    end
    else if (!o_slave_ac.mastlock)
    begin
      next_hsel_lock = 1'b0;                             // Lock released
    end
    else
    begin
      next_hsel_lock = hsel_lock;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hsel_lock <= 1'b0;
    end
    else if (i_hreadymux)
    begin
      hsel_lock <= next_hsel_lock;                       // Only at transfer boundary
    end
  end

  // Lock counts only once the sequence reached this slave
  assign o_lock_arb = o_slave_ac.mastlock & (hsel_lock | o_slave_ac.sel);

  // Never two owners at once
  a_active_onehot : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $onehot0(o_active)
  );

endmodule

`default_nettype wire

//--- logic/output_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_settings.svh"

module output_arb (
  input  wire                            HCLK,          // AHB clock
  input  wire                            HRESETn,       // Sync reset, active low
  input  wire ahb_outstg_pkg::addr_ctrl_arr_t i_port_ac,  // Address phase per port
  input  wire                            i_lock_arb,    // Locked sequence in progress
  input  wire                            i_hreadymux,   // Transfer accepted this cycle
  input  wire [1:0]                      i_cur_trans,   // HTRANS of the granted port
  output ahb_outstg_pkg::grant_t         o_grant        // Registered grant
);

  // ----------------------------------------------------------
  // Requests
  // ----------------------------------------------------------
  ahb_outstg_pkg::port_mask_t req;                       // Port wants the slave
  ahb_outstg_pkg::grant_t     next_grant;                // Fixed-priority winner
  logic                       burst_cont;                // Burst not yet finished
  logic                       hold_grant;                // Keep current owner

  // A port only competes while its input stage holds a transfer for us
  always_comb
  begin
    for (int p = 0; p < `OUTSTG_N_PORTS; p++)
    begin
      req[p] = i_port_ac[p].sel & i_port_ac[p].held_tran;  // Selected and pending
    end
  end

  // ----------------------------------------------------------
  // Fixed priority, port 0 highest
  // ----------------------------------------------------------
  always_comb
  begin
    next_grant = '0;                                     // Nobody requesting
    for (int p = `OUTSTG_N_PORTS - 1; p >= 0; p--)
    begin
      if (req[p])
      begin
        next_grant.valid = 1'b1;                         // Lower index overwrites
        next_grant.idx   = ahb_outstg_pkg::port_idx_t'(p);
      end
    end
  end

  // Middle of a burst, the owner must keep the slave
  assign burst_cont = (i_cur_trans == `OUTSTG_TRANS_BUSY) ||
                      (i_cur_trans == `OUTSTG_TRANS_SEQ);

  // Locked sequences and bursts pin the current owner
  assign hold_grant = o_grant.valid & (i_lock_arb | burst_cont);

  // ----------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_grant <= '0;                                     // No owner out of reset
    end
    else if (i_hreadymux)
    begin
      if (!hold_grant)
      begin
        o_grant <= next_grant;                           // Re-arbitrate at transfer end
      end
    end
  end

  // Ownership may only move on an accepted transfer
  a_grant_frozen_on_wait : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> $stable(o_grant)
  );

endmodule

`default_nettype wire

//--- logic/ahb_outstg_pkg.sv
`default_nettype none

`include "ahb_outstg_settings.svh"

package ahb_outstg_pkg;

  // ----------------------------------------------------------
  // Port indexing
  // ----------------------------------------------------------
  typedef logic [$clog2(`OUTSTG_N_PORTS)-1:0] port_idx_t;   // Input port number

  typedef logic [`OUTSTG_N_PORTS-1:0] port_mask_t;          // One bit per input port

  // Arbitration result, idx only meaningful with valid set
  typedef struct packed {
    logic      valid;                                       // Some port owns the slave
    port_idx_t idx;                                         // Owning port
  } grant_t;

  // ----------------------------------------------------------
  // Address phase of one port
  // ----------------------------------------------------------
  typedef struct packed {
    logic                      sel;                         // HSEL
    logic [`OUTSTG_ADDR_W-1:0] addr;                        // HADDR
    logic [1:0]                trans;                       // HTRANS
    logic                      write;                       // HWRITE
    logic [2:0]                size;                        // HSIZE
    logic [2:0]                burst;                       // HBURST
    logic [3:0]                prot;                        // HPROT
    logic [3:0]                master;                      // HMASTER
    logic                      mastlock;                    // HMASTLOCK
    logic                      held_tran;                   // Input stage holds a transfer
  } addr_ctrl_t;

  // ----------------------------------------------------------
  // Per-port bundles
  // ----------------------------------------------------------
  typedef addr_ctrl_t [`OUTSTG_N_PORTS-1:0] addr_ctrl_arr_t;                  // All ports

  typedef logic [`OUTSTG_N_PORTS-1:0][`OUTSTG_DATA_W-1:0] wdata_arr_t;      // All HWDATA

endpackage

`default_nettype wire

//--- logic/ahb_outstg_settings.svh
`ifndef AHB_OUTSTG_SETTINGS_SVH
`define AHB_OUTSTG_SETTINGS_SVH

// ----------------------------------------------------------
// Output stage sizing
// ----------------------------------------------------------
`define OUTSTG_N_PORTS      3        // Input ports sharing the slave
`define OUTSTG_ADDR_W       32       // HADDR width
`define OUTSTG_DATA_W       32       // HWDATA width

// ----------------------------------------------------------
// HTRANS encodings
// ----------------------------------------------------------
`define OUTSTG_TRANS_IDLE   2'b00    // No transfer
`define OUTSTG_TRANS_BUSY   2'b01    // Burst paused by master
`define OUTSTG_TRANS_NONSEQ 2'b10    // First beat or single
`define OUTSTG_TRANS_SEQ    2'b11    // Burst continuation

`endif
